// File: common/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

//////////////////////////////////////////////////
// Decode stage widths
//////////////////////////////////////////////////

// Data path width, RV32I
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32

`endif

// File: common/rv_decode_pkg.sv
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

    //////////////////////////////////////////////////
    // Plain vectors
    //////////////////////////////////////////////////

    typedef logic [`RV_XLEN-1:0]             word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [$clog2(`RV_XLEN)-1:0]     shamt_t;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_t;

    // Zero is the bubble operation
    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_SLL  = 5'd3,
        ALU_SLT  = 5'd4,
        ALU_SLTU = 5'd5,
        ALU_XOR  = 5'd6,
        ALU_SRL  = 5'd7,
        ALU_SRA  = 5'd8,
        ALU_OR   = 5'd9,
        ALU_AND  = 5'd10,
        ALU_BEQ  = 5'd11,
        ALU_BNE  = 5'd12,
        ALU_BLT  = 5'd13,
        ALU_BGE  = 5'd14,
        ALU_BLTU = 5'd15,
        ALU_BGEU = 5'd16,
        ALU_JAL  = 5'd17,
        ALU_LUI  = 5'd18
    } alu_op_t;

    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_t;

    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_t;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        shamt_t    shamt;
        alu_op_t   alu_op;
        logic      alu_src1_pc;
        logic      alu_src2_imm;
        load_t     load;
        store_t    store;
        logic      wb_from_mem;
        logic      rd_we;
    } decode_ctrl_t;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        logic      we;
    } wb_port_t;

    typedef struct packed {
        word_t        pc;
        word_t        imm;
        word_t        rs1_data;
        word_t        rs2_data;
        word_t        store_data;
        decode_ctrl_t ctrl;
    } id_ex_t;

endpackage

// File: decode/imm_extender.sv
`timescale 1ns/1ps

`include "rv_decode_cfg.svh"

module imm_extender (
    input  logic [24:0]             bits,
    input  rv_decode_pkg::imm_fmt_t fmt,
    output rv_decode_pkg::word_t    imm
);

    import rv_decode_pkg::*;

    // bits[k] holds instruction bit k+7, so bits[24] is the sign
    logic sign;

    assign sign = bits[24];

    always_comb
    begin
        case (fmt)
            IMM_I:
                imm = {{(`RV_XLEN-12){sign}}, bits[24:13]};
            IMM_S:
                imm = {{(`RV_XLEN-12){sign}}, bits[24:18], bits[4:0]};
            // imm[12|10:5|4:1|11] with bit 0 implied zero
            IMM_B:
                imm = {{(`RV_XLEN-12){sign}}, bits[0], bits[23:18], bits[4:1], 1'b0};
            IMM_U:
                imm = {bits[24:5], 12'b0};
            // imm[20|10:1|11|19:12]
            IMM_J:
                imm = {{(`RV_XLEN-20){sign}}, bits[12:5], bits[13], bits[23:14], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: decode/register_file.sv
`timescale 1ns/1ps

`include "rv_decode_cfg.svh"

module register_file (
    input  logic                     CLK,
    input  logic                     rst,
    input  rv_decode_pkg::reg_addr_t rs1_addr,
    input  rv_decode_pkg::reg_addr_t rs2_addr,
    output rv_decode_pkg::word_t     rs1_data,
    output rv_decode_pkg::word_t     rs2_data,
    input  rv_decode_pkg::wb_port_t  wb
);

    import rv_decode_pkg::*;

    word_t regs [`RV_NUM_REGS];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Writes to x0 are dropped
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.we && (wb.addr != '0))
        begin
            regs[wb.addr] <= wb.data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // No bypass, same-cycle write shows up next cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: decode/ins_decoder.sv
`timescale 1ns/1ps

module ins_decoder (
    input  rv_decode_pkg::word_t        instr,
    output rv_decode_pkg::decode_ctrl_t ctrl,
    output rv_decode_pkg::word_t        imm
);

    import rv_decode_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    imm_fmt_t   fmt;
    logic       valid;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Bit 30 picks SUB only for register ops, SRA/SRAI for both
    function automatic alu_op_t alu_op_from_funct3(input logic [2:0] f3,
                                                   input logic       alt,
                                                   input logic       reg_op);
        alu_op_t op;
        case (f3)
            3'b000:  op = (alt && reg_op) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////

    always_comb
    begin
        ctrl    = '0;
        fmt     = IMM_NONE;
        valid   = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_LUI:
            begin
                fmt               = IMM_U;
                ctrl.alu_op       = ALU_LUI;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.rd_we        = 1'b1;
            end
            OPC_AUIPC, OPC_JAL:
            begin
                fmt               = (opcode == OPC_JAL) ? IMM_J : IMM_U;
                ctrl.alu_op       = (opcode == OPC_JAL) ? ALU_JAL : ALU_ADD;
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.rd_we        = 1'b1;
            end
            OPC_JALR:
            begin
                fmt               = IMM_I;
                use_rs1           = 1'b1;
                ctrl.alu_op       = ALU_JAL;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.rd_we        = 1'b1;
            end
            OPC_BRANCH:
            begin
                fmt     = IMM_B;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_BEQ;
                    3'b001:  ctrl.alu_op = ALU_BNE;
                    3'b100:  ctrl.alu_op = ALU_BLT;
                    3'b101:  ctrl.alu_op = ALU_BGE;
                    3'b110:  ctrl.alu_op = ALU_BLTU;
                    3'b111:  ctrl.alu_op = ALU_BGEU;
                    default: valid = 1'b0;
                endcase
            end
            OPC_LOAD:
            begin
                fmt               = IMM_I;
                use_rs1           = 1'b1;
                ctrl.alu_op       = ALU_ADD;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.wb_from_mem  = 1'b1;
                ctrl.rd_we        = 1'b1;
                case (funct3)
                    3'b000:  ctrl.load = LOAD_LB;
                    3'b001:  ctrl.load = LOAD_LH;
                    3'b010:  ctrl.load = LOAD_LW;
                    3'b100:  ctrl.load = LOAD_LBU;
                    3'b101:  ctrl.load = LOAD_LHU;
                    default: valid = 1'b0;
                endcase
            end
            OPC_STORE:
            begin
                fmt               = IMM_S;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
                ctrl.alu_op       = ALU_ADD;
                ctrl.alu_src2_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.store = STORE_SB;
                    3'b001:  ctrl.store = STORE_SH;
                    3'b010:  ctrl.store = STORE_SW;
                    default: valid = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                fmt               = IMM_I;
                use_rs1           = 1'b1;
                ctrl.alu_op       = alu_op_from_funct3(funct3, instr[30], 1'b0);
                ctrl.alu_src2_imm = 1'b1;
                ctrl.rd_we        = 1'b1;
                if ((funct3 == 3'b001) || (funct3 == 3'b101))
                begin
                    ctrl.shamt = instr[24:20];
                end
            end
            OPC_OP:
            begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                ctrl.alu_op = alu_op_from_funct3(funct3, instr[30], 1'b1);
                ctrl.rd_we  = 1'b1;
            end
            default:
                valid = 1'b0;
        endcase

        // Unused register fields leave as zero
        ctrl.rs1 = use_rs1 ? instr[19:15] : '0;
        ctrl.rs2 = use_rs2 ? instr[24:20] : '0;
        ctrl.rd  = ctrl.rd_we ? instr[11:7] : '0;

        // Anything not recognised becomes a bubble
        if (!valid)
        begin
            ctrl = '0;
            fmt  = IMM_NONE;
        end
    end

    imm_extender imm_ext0 (
        .bits (instr[31:7]),
        .fmt  (fmt),
        .imm  (imm)
    );

endmodule

// File: rtl/decoding_stage.sv
`timescale 1ns/1ps

module decoding_stage (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    clear,
    input  rv_decode_pkg::word_t    instr,
    input  rv_decode_pkg::word_t    pc,
    input  rv_decode_pkg::wb_port_t wb,
    output rv_decode_pkg::id_ex_t   id_ex
);

    import rv_decode_pkg::*;

    decode_ctrl_t ctrl;
    word_t        imm;
    word_t        rs1_data;
    word_t        rs2_data;

    //////////////////////////////////////////////////
    // Decode and operand read, same instruction word
    //////////////////////////////////////////////////

    ins_decoder decoder0 (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    // Addresses come straight from the decoder, zero when unused
    register_file regfile0 (
        .CLK      (CLK),
        .rst      (rst),
        .rs1_addr (ctrl.rs1),
        .rs2_addr (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    //////////////////////////////////////////////////
    // ID/EX stage register
    //////////////////////////////////////////////////

    // Clear beats stall, rst behaves as clear
    always_ff @(posedge CLK)
    begin
        if (rst || clear)
        begin
            id_ex <= '0;
        end
        else if (!stall)
        begin
            id_ex.pc         <= pc;
            id_ex.imm        <= imm;
            id_ex.rs1_data   <= rs1_data;
            id_ex.rs2_data   <= rs2_data;
            // Store data is the rs2 operand as read here
            id_ex.store_data <= rs2_data;
            id_ex.ctrl       <= ctrl;
        end
    end

endmodule

// File: dv/decoding_stage_checker.sv
`timescale 1ns/1ps

module decoding_stage_checker (
    input logic                  CLK,
    input logic                  rst,
    input logic                  stall,
    input logic                  clear,
    input rv_decode_pkg::id_ex_t id_ex
);

    import rv_decode_pkg::*;

    int fail_count = 0;

    //////////////////////////////////////////////////
    // Stage register rules
    //////////////////////////////////////////////////

    // Bubble one edge after rst or clear
    bubble_after_clear: assert property (@(posedge CLK) (rst || clear) |=> (id_ex == '0))
    else
    begin
        fail_count++;
        $error("id_ex is not zero after rst or clear");
    end

    // Stall holds the register
    hold_on_stall: assert property (@(posedge CLK) (stall && !clear && !rst) |=> $stable(id_ex))
    else
    begin
        fail_count++;
        $error("id_ex changed while stalled");
    end

    // No instruction both stores and writes rd
    store_or_write: assert property (@(posedge CLK) disable iff (rst)
        !(id_ex.ctrl.rd_we && (id_ex.ctrl.store != STORE_NONE)))
    else
    begin
        fail_count++;
        $error("rd_we and store are both active");
    end

endmodule

// File: dv/decoding_stage_monitor.sv
`timescale 1ns/1ps

module decoding_stage_monitor (
    input  logic                  CLK,
    input  rv_decode_pkg::id_ex_t id_ex,
    output int                    checks,
    output int                    errors
);

    import rv_decode_pkg::*;

    // Written by the testbench right before case_ev fires
    event            case_ev;
    id_ex_t          exp_in;
    logic [8*24-1:0] name_in;

    id_ex_t          exp_next;
    id_ex_t          exp_cur;
    logic [8*24-1:0] name_next;
    logic [8*24-1:0] name_cur;
    logic            next_valid = 1'b0;
    logic            cur_valid  = 1'b0;
    int              n_checks   = 0;
    int              n_errors   = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected)
        begin
            n_errors++;
            $display("FAIL %0s %0s: expected %h, actual %h", name_cur, field, expected, actual);
        end
    endtask

    always @(case_ev)
    begin
        exp_next   = exp_in;
        name_next  = name_in;
        next_valid = 1'b1;
    end

    // Case driven last cycle gets captured at this edge
    always @(posedge CLK)
    begin
        exp_cur    = exp_next;
        name_cur   = name_next;
        cur_valid  = next_valid;
        next_valid = 1'b0;
    end

    // id_ex has settled by the falling edge
    always @(negedge CLK)
    begin
        if (cur_valid)
        begin
            compare_field("pc", exp_cur.pc, id_ex.pc);
            compare_field("imm", exp_cur.imm, id_ex.imm);
            compare_field("rs1_data", exp_cur.rs1_data, id_ex.rs1_data);
            compare_field("rs2_data", exp_cur.rs2_data, id_ex.rs2_data);
            compare_field("store_data", exp_cur.store_data, id_ex.store_data);
            compare_field("rs1", exp_cur.ctrl.rs1, id_ex.ctrl.rs1);
            compare_field("rs2", exp_cur.ctrl.rs2, id_ex.ctrl.rs2);
            compare_field("rd", exp_cur.ctrl.rd, id_ex.ctrl.rd);
            compare_field("shamt", exp_cur.ctrl.shamt, id_ex.ctrl.shamt);
            compare_field("alu_op", exp_cur.ctrl.alu_op, id_ex.ctrl.alu_op);
            compare_field("alu_src1_pc", exp_cur.ctrl.alu_src1_pc, id_ex.ctrl.alu_src1_pc);
            compare_field("alu_src2_imm", exp_cur.ctrl.alu_src2_imm, id_ex.ctrl.alu_src2_imm);
            compare_field("load", exp_cur.ctrl.load, id_ex.ctrl.load);
            compare_field("store", exp_cur.ctrl.store, id_ex.ctrl.store);
            compare_field("wb_from_mem", exp_cur.ctrl.wb_from_mem, id_ex.ctrl.wb_from_mem);
            compare_field("rd_we", exp_cur.ctrl.rd_we, id_ex.ctrl.rd_we);
            n_checks++;
            cur_valid = 1'b0;
        end
    end

endmodule

// File: dv/decoding_stage_tb.sv
`timescale 1ns/1ps

module decoding_stage_tb;

    import rv_decode_pkg::*;

    localparam CASE_FILE = "dv/decode_cases.txt";

    logic     CLK;
    logic     rst;
    logic     stall;
    logic     clear;
    word_t    instr;
    word_t    pc;
    wb_port_t wb;
    id_ex_t   id_ex;
    id_ex_t   last_exp;
    int       checks;
    int       value_errors;
    int       other_errors = 0;
    int       posted       = 0;
    int       cycles       = 0;
    int       cycle_limit  = 0;

    decoding_stage dut0 (
        .CLK   (CLK),
        .rst   (rst),
        .stall (stall),
        .clear (clear),
        .instr (instr),
        .pc    (pc),
        .wb    (wb),
        .id_ex (id_ex)
    );

    decoding_stage_monitor mon0 (
        .CLK    (CLK),
        .id_ex  (id_ex),
        .checks (checks),
        .errors (value_errors)
    );

    bind decoding_stage decoding_stage_checker chk0 (
        .CLK   (CLK),
        .rst   (rst),
        .stall (stall),
        .clear (clear),
        .id_ex (id_ex)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if ((cycle_limit > 0) && (cycles >= cycle_limit))
        begin
            $display("Timeout after %0d cycles, only %0d of %0d cases were checked",
                     cycles, checks, posted);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int count_lines();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        n  = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) > 0)
            begin
                n++;
            end
            $fclose(fd);
        end
        return n;
    endfunction

    task automatic post_case(input logic [8*24-1:0] name, input id_ex_t expected);
        mon0.exp_in  = expected;
        mon0.name_in = name;
        last_exp     = expected;
        posted++;
        -> mon0.case_ev;
    endtask

    //////////////////////////////////////////////////
    // Case file driver
    //////////////////////////////////////////////////

    task automatic run_cases(input int fd);
        logic [8*8-1:0]   kind;
        logic [8*24-1:0]  name;
        logic [8*128-1:0] rest;
        word_t            f [3];
        int               c [11];
        int               got;
        int               want;
        id_ex_t           exp;
        while ($fscanf(fd, "%s", kind) == 1)
        begin
            if (kind == "#")
            begin
                got = $fgets(rest, fd);
                continue;
            end
            wb    = '0;
            stall = 1'b0;
            clear = 1'b0;
            instr = '0;
            pc    = '0;
            exp   = '0;
            if (kind == "W")
            begin
                want    = 3;
                got     = $fscanf(fd, "%s %h %h", name, c[0], f[0]);
                wb.addr = reg_addr_t'(c[0]);
                wb.data = f[0];
                wb.we   = 1'b1;
            end
            else if (kind == "S")
            begin
                want  = 3;
                got   = $fscanf(fd, "%s %h %h", name, instr, pc);
                stall = 1'b1;
                exp   = last_exp;
            end
            else if (kind == "C")
            begin
                want  = 4;
                got   = $fscanf(fd, "%s %h %h %d", name, instr, pc, c[0]);
                stall = c[0][0];
                clear = 1'b1;
            end
            else if (kind == "D")
            begin
                want = 17;
                got  = $fscanf(fd, "%s %h %h %h %h %h %d %d %d %d %d %d %d %d %d %d %d",
                               name, instr, pc, f[0], f[1], f[2], c[0], c[1], c[2], c[3],
                               c[4], c[5], c[6], c[7], c[8], c[9], c[10]);
                exp.pc                = pc;
                exp.imm               = f[0];
                exp.rs1_data          = f[1];
                exp.rs2_data          = f[2];
                exp.store_data        = f[2];
                exp.ctrl.rs1          = reg_addr_t'(c[0]);
                exp.ctrl.rs2          = reg_addr_t'(c[1]);
                exp.ctrl.rd           = reg_addr_t'(c[2]);
                exp.ctrl.shamt        = shamt_t'(c[3]);
                exp.ctrl.alu_op       = alu_op_t'(c[4]);
                exp.ctrl.alu_src1_pc  = c[5][0];
                exp.ctrl.alu_src2_imm = c[6][0];
                exp.ctrl.load         = load_t'(c[7]);
                exp.ctrl.store        = store_t'(c[8]);
                exp.ctrl.wb_from_mem  = c[9][0];
                exp.ctrl.rd_we        = c[10][0];
            end
            else
            begin
                $display("Case file holds an unknown record kind %0s", kind);
                other_errors++;
                got = $fgets(rest, fd);
                continue;
            end
            if (got != want)
            begin
                $display("Case %0s has missing fields, %0d of %0d read", name, got, want);
                other_errors++;
            end
            post_case(name, exp);
            @(posedge CLK);
            #1;
        end
    endtask

    initial
    begin
        int fd;
        CLK      = 1'b0;
        rst      = 1'b1;
        stall    = 1'b0;
        clear    = 1'b0;
        instr    = '0;
        pc       = '0;
        wb       = '0;
        last_exp = '0;
        // Four cycles per file line plus slack
        cycle_limit = 4 * count_lines() + 100;
        fd = $fopen(CASE_FILE, "r");
        repeat (16) @(posedge CLK);
        #1;
        rst = 1'b0;
        if (fd == 0)
        begin
            $display("Could not open the case file %0s", CASE_FILE);
            other_errors++;
        end
        else
        begin
            run_cases(fd);
            $fclose(fd);
        end
        wb    = '0;
        stall = 1'b0;
        clear = 1'b0;
        instr = '0;
        while (checks < posted)
        begin
            @(posedge CLK);
        end
        $display("Summary: %0d cases %0d checked, errors: %0d value %0d assert %0d other",
                 posted, checks, value_errors, dut0.chk0.fail_count, other_errors);
        if ((value_errors == 0) && (dut0.chk0.fail_count == 0) &&
            (other_errors == 0) && (posted > 0))
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/decode_cases.txt
# W name addr data | S name instr pc (stall) | C name instr pc stall (clear)
# D name instr pc imm rs1_data rs2_data rs1 rs2 rd shamt alu_op src1_pc src2_imm load store wbm rd_we
# Values in hex up to rs2_data, control fields in decimal
S reset_hold       00000013 100
D add_unwritten    006281b3 104 00000000 00000000 00000000 5 6 3 0 1 0 0 0 0 0 1
W wr_x5            5 00000040
W wr_x6            6 fffffff0
W wr_x7            7 12345678
W wr_x0            0 deadbeef
D sub              40628433 108 00000000 00000040 fffffff0 5 6 8 0 2 0 0 0 0 0 1
D sra_x0           4003d4b3 10c 00000000 12345678 00000000 7 0 9 0 8 0 0 0 0 0 1
D addi_neg         fff28513 110 ffffffff 00000040 00000000 5 0 10 0 1 0 1 0 0 0 1
D srai             40435593 114 00000404 fffffff0 00000000 6 0 11 4 8 0 1 0 0 0 1
D lw_neg           ff83a603 118 fffffff8 12345678 00000000 7 0 12 0 1 0 1 3 0 1 1
D lbu_pos          7ff2c683 11c 000007ff 00000040 00000000 5 0 13 0 1 0 1 4 0 1 1
D sw_neg           fe72ae23 120 fffffffc 00000040 12345678 5 7 0 0 1 0 1 0 3 0 0
D sb_pos           026382a3 124 00000025 12345678 fffffff0 7 6 0 0 1 0 1 0 1 0 0
D bne_neg          fe6298e3 128 fffffff0 00000040 fffffff0 5 6 0 0 12 0 0 0 0 0 0
D beq_pos          000380e3 12c 00000800 12345678 00000000 7 0 0 0 11 0 0 0 0 0 0
D jal_neg          ffdff0ef 130 fffffffc 00000000 00000000 0 0 1 0 17 1 1 0 0 0 1
D jal_pos          0051216f 134 00012804 00000000 00000000 0 0 2 0 17 1 1 0 0 0 1
D jalr             00c380e7 138 0000000c 12345678 00000000 7 0 1 0 17 0 1 0 0 0 1
D lui_neg          80001737 13c 80001000 00000000 00000000 0 0 14 0 18 0 1 0 0 0 1
D auipc_pos        12345797 140 12345000 00000000 00000000 0 0 15 0 1 1 1 0 0 0 1
S stall_hold       fff28513 144
C clear_only       00c380e7 148 0
D addi_after_clear fff28513 14c ffffffff 00000040 00000000 5 0 10 0 1 0 1 0 0 0 1
C clear_stall      40628433 150 1
D fence            0000000f 154 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0
D ecall            00000073 158 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0

// File: compile.f
+incdir+common
common/rv_decode_pkg.sv
decode/imm_extender.sv
decode/register_file.sv
decode/ins_decoder.sv
rtl/decoding_stage.sv
dv/decoding_stage_checker.sv
dv/decoding_stage_monitor.sv
dv/decoding_stage_tb.sv

// File: Bender.yml
package:
  name: rv_decode_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_decode_pkg.sv
      - decode/imm_extender.sv
      - decode/register_file.sv
      - decode/ins_decoder.sv
      - rtl/decoding_stage.sv
  - target: test
    files:
      - dv/decoding_stage_checker.sv
      - dv/decoding_stage_monitor.sv
      - dv/decoding_stage_tb.sv
